/* sources.f */
source/permutePkg.sv
source/delayLine.sv
source/topReceiver.sv
source/varSwap.sv
source/permuteCheck.sv
source/aggregatingLane.sv
source/permuteAggregateTop.sv
testbench/permuteAggregate_assert.sv
testbench/permuteAggregateTb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = permuteAggregateTb
RTL_TOP   = permuteAggregateTop
FILELIST  = sources.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = all tests passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* testbench/permuteAggregateTb.sv */
`timescale 1ns/1ps

module permuteAggregateTb import permutePkg::*; ();

    localparam int CLK_PERIOD = 20;
    localparam int TEST_COUNT = 5;
    localparam int BATCH_CYCLES = 100;  // generous bound on one test
    localparam int WATCHDOG_NS = TEST_COUNT * BATCH_CYCLES * CLK_PERIOD + 2000;
    localparam int RESULT_WAIT = 20;

    logic                         clk;
    logic                         rstN;
    logic [1:0]                   topChannel;
    logic                         topShift;
    botT                          bot;
    logic                         botValid;
    logic                         batchDone;
    logic                         grabResults;
    logic                         slowDownInput;
    logic                         resultsAvailable;
    logic [TOTAL_SUM_WIDTH-1:0]   pcoeffSum;
    logic [TOTAL_COUNT_WIDTH-1:0] pcoeffCount;
    logic [2:0]                   activityMeasure;

    botT topModel;  // top as the DUT should hold it
    int  checkCount;
    int  errorCount;

    permuteAggregateTop dut (
        .clk              (clk),
        .rstN             (rstN),
        .topChannel       (topChannel),
        .topShift         (topShift),
        .bot              (bot),
        .botValid         (botValid),
        .batchDone        (batchDone),
        .slowDownInput    (slowDownInput),
        .grabResults      (grabResults),
        .resultsAvailable (resultsAvailable),
        .pcoeffSum        (pcoeffSum),
        .pcoeffCount      (pcoeffCount),
        .activityMeasure  (activityMeasure)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // exchange variables va and vb of a truth table
    function automatic botT swapVars(botT b, int va, int vb);
        botT r;
        int  src;
        for (int k = 0; k < BOT_WIDTH; k++) begin
            src = k;
            if (((k >> va) & 1) != ((k >> vb) & 1)) begin
                src = k ^ ((1 << va) | (1 << vb));  // flip both when the two variables differ
            end
            r[k] = b[src];
        end
        return r;
    endfunction

    function automatic int popcount(botT v);
        int n = 0;
        for (int i = 0; i < BOT_WIDTH; i++) begin
            if (v[i]) begin
                n++;
            end
        end
        return n;
    endfunction

    // adds one bot's four permutations to the expected totals
    function automatic void modelBot(botT topV, botT b, inout int sumV, inout int countV);
        botT p;
        for (int lane = 0; lane < LANE_COUNT; lane++) begin
            p = (lane == 0) ? b : swapVars(b, 0, lane);
            if ((p & ~topV) == '0) begin
                countV++;
                sumV += popcount(topV & ~p);
            end
        end
    endfunction

    task automatic checkValue(string name, logic [31:0] actual, logic [31:0] expected);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("mismatch %s: got 0x%0h, expected 0x%0h at %0t", name, actual, expected,
                     $time);
        end
    endtask

    task automatic nextCycle();
        @(posedge clk);
        #2;
    endtask

    task automatic driveCycle(botT b, logic valid, logic done);
        bot = b;
        botValid = valid;
        batchDone = done;
        nextCycle();
    endtask

    task automatic loadTop(botT value);
        for (int i = 0; i < BOT_WIDTH / 2; i++) begin
            topChannel = value[BOT_WIDTH-1-2*i -: 2];  // most significant pair first
            topShift = 1'b1;
            nextCycle();
        end
        topShift = 1'b0;
        topModel = value;
        checkValue("top", 32'(dut.top), 32'(value));
    endtask

    task automatic awaitResults(int expSum, int expCount);
        int cycles = 0;
        botValid = 1'b0;
        batchDone = 1'b0;
        while (!resultsAvailable && cycles < RESULT_WAIT) begin
            nextCycle();
            cycles++;
        end
        if (!resultsAvailable) begin
            errorCount++;
            $display("resultsAvailable never rose after batchDone at %0t", $time);
        end else begin
            checkValue("pcoeffSum", 32'(pcoeffSum), expSum);
            checkValue("pcoeffCount", 32'(pcoeffCount), expCount);
            checkValue("slowDownInput", 32'(slowDownInput), 1);
        end
    endtask

    task automatic releaseResults();
        int cycles = 0;
        grabResults = 1'b1;
        nextCycle();
        grabResults = 1'b0;
        while (resultsAvailable && cycles < RESULT_WAIT) begin
            nextCycle();
            cycles++;
        end
        if (resultsAvailable) begin
            errorCount++;
            $display("resultsAvailable stayed high after grabResults at %0t", $time);
        end else begin
            checkValue("slowDownInput", 32'(slowDownInput), 0);
        end
    endtask

    task automatic resetTest();
        checkValue("resultsAvailable", 32'(resultsAvailable), 0);
        checkValue("slowDownInput", 32'(slowDownInput), 0);
        checkValue("activityMeasure", 32'(activityMeasure), 0);
    endtask

    // bit 8 only fits below 00ff once variables 0 and 3 trade places
    task automatic singleBotTest();
        int expSum = 0;
        int expCount = 0;
        loadTop(16'h00ff);
        modelBot(topModel, 16'h0100, expSum, expCount);
        driveCycle(16'h0100, 1'b1, 1'b1);
        awaitResults(expSum, expCount);
        releaseResults();
    endtask

    task automatic randomBatchTest();
        int  expSum = 0;
        int  expCount = 0;
        botT b;
        loadTop(botT'($urandom()) | 16'h8001);
        for (int i = 0; i < 30; i++) begin
            b = botT'($urandom()) & topModel;  // masked so most permutations fit
            if (i < 29 && $urandom_range(3) == 0) begin
                driveCycle(botT'($urandom()), 1'b0, 1'b0);  // gap with junk payload
            end else begin
                modelBot(topModel, b, expSum, expCount);
                driveCycle(b, 1'b1, i == 29);
            end
        end
        awaitResults(expSum, expCount);
        releaseResults();
    endtask

    task automatic holdAndGrabTest();
        int expSum = 0;
        int expCount = 0;
        modelBot(topModel, 16'h0001, expSum, expCount);
        driveCycle(16'h0001, 1'b1, 1'b0);
        modelBot(topModel, topModel, expSum, expCount);
        driveCycle(topModel, 1'b1, 1'b1);
        awaitResults(expSum, expCount);
        repeat (6) begin
            nextCycle();
            checkValue("slowDownInput", 32'(slowDownInput), 1);
            checkValue("pcoeffSum", 32'(pcoeffSum), expSum);
        end
        releaseResults();
        driveCycle('0, 1'b0, 1'b1);  // empty batch
        awaitResults(0, 0);
        releaseResults();
    endtask

    task automatic activityTest();
        int oneSum = 0;
        int perBot = 0;
        loadTop(16'h00ff);
        modelBot(topModel, 16'h0003, oneSum, perBot);
        for (int i = 0; i < 10; i++) begin
            driveCycle(16'h0003, 1'b1, i == 9);
            if (i >= 4) begin
                checkValue("activityMeasure", 32'(activityMeasure), perBot);
            end
        end
        awaitResults(10 * oneSum, 10 * perBot);
        checkValue("activityMeasure", 32'(activityMeasure), 0);  // stream has stopped
        releaseResults();
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("checks: %0d  errors: %0d", checkCount, errorCount + 1);
        $display("tests failed");
        $finish;
    end

    initial begin
        void'($urandom(32'h801d));
        rstN = 1'b0;
        topChannel = '0;
        topShift = 1'b0;
        bot = '0;
        botValid = 1'b0;
        batchDone = 1'b0;
        grabResults = 1'b0;
        topModel = '0;
        checkCount = 0;
        errorCount = 0;
        repeat (2) @(posedge clk);
        #2;
        rstN = 1'b1;

        resetTest();
        singleBotTest();
        randomBatchTest();
        holdAndGrabTest();
        activityTest();

        $display("checks: %0d  errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

/* testbench/permuteAggregate_assert.sv */
`timescale 1ns/1ps

module permuteAggregateAssert (
    input logic clk,
    input logic rstN,
    input logic botValid,
    input logic batchDone,
    input logic grabResults,
    input logic slowDownInput,
    input logic resultsAvailable
);

    // producer holds off while results wait to be grabbed
    inputHeldOff: assert property (@(posedge clk) disable iff (!rstN)
        slowDownInput |-> !(botValid || batchDone))
        else $error("botValid or batchDone high while slowDownInput is high");

    // back-pressure only lifts three cycles after a grab
    slowDownReleasedByGrab: assert property (@(posedge clk) disable iff (!rstN)
        $fell(slowDownInput) |-> $past(grabResults, 3))
        else $error("slowDownInput fell without a grabResults three cycles before");

    resetClearsResults: assert property (@(posedge clk) !rstN |=> !resultsAvailable)
        else $error("resultsAvailable high in the cycle after reset");

endmodule

bind permuteAggregateTop permuteAggregateAssert assertions (
    .clk              (clk),
    .rstN             (rstN),
    .botValid         (botValid),
    .batchDone        (batchDone),
    .grabResults      (grabResults),
    .slowDownInput    (slowDownInput),
    .resultsAvailable (resultsAvailable)
);

/* source/permuteAggregateTop.sv */
`timescale 1ns/1ps

module permuteAggregateTop import permutePkg::*; (
    input  logic                         clk,
    input  logic                         rstN,

    // top bound loaded two bits per strobe
    input  logic [1:0]                   topChannel,
    input  logic                         topShift,

    // bot stream
    input  botT                          bot,
    input  logic                         botValid,
    input  logic                         batchDone,
    output logic                         slowDownInput,

    // results
    input  logic                         grabResults,
    output logic                         resultsAvailable,
    output logic [TOTAL_SUM_WIDTH-1:0]   pcoeffSum,
    output logic [TOTAL_COUNT_WIDTH-1:0] pcoeffCount,

    output logic [2:0]                   activityMeasure
);

    botT                   top;
    botT                   permuted [LANE_COUNT];
    botT                   checkedBots [LANE_COUNT];
    logic [LANE_COUNT-1:0] belowTop;

    botT                   botD;
    logic [1:0]            flagsD;      // {valid, done} aligned with the check
    logic [LANE_COUNT-1:0] accept;

    logic [LANE_COUNT-1:0] resultReady;
    logic [SUM_WIDTH-1:0]   laneSums [LANE_COUNT];
    logic [COUNT_WIDTH-1:0] laneCounts [LANE_COUNT];
    logic                  laneGrab;

    logic [SUM_WIDTH:0]    sum01;
    logic [SUM_WIDTH:0]    sum23;
    logic [COUNT_WIDTH:0]  count01;
    logic [COUNT_WIDTH:0]  count23;
    logic                  allReady;
    logic [1:0]            act01;
    logic [1:0]            act23;

    topReceiver receiver (
        .clk        (clk),
        .rstN       (rstN),
        .topChannel (topChannel),
        .topShift   (topShift),
        .top        (top)
    );

    // lane 0 is the identity and lane i swaps variables 0 and i
    assign permuted[0] = bot;
    for (genvar i = 1; i < LANE_COUNT; i++) begin : gSwap
        varSwap #(.VAR_A(0), .VAR_B(i)) swap (
            .botIn  (bot),
            .botOut (permuted[i])
        );
    end

    permuteCheck belowTopCheck (
        .clk      (clk),
        .rstN     (rstN),
        .top      (top),
        .bots     (permuted),
        .botValid (botValid),
        .botsOut  (checkedBots),
        .belowTop (belowTop)
    );

    delayLine #(.CYCLES(CHECK_LATENCY), .T(botT)) botPipe (
        .clk  (clk),
        .din  (bot),
        .dout (botD)
    );

    delayLine #(.CYCLES(CHECK_LATENCY), .T(logic [1:0])) flagPipe (
        .clk  (clk),
        .din  ({botValid, batchDone}),
        .dout (flagsD)
    );

    assign accept   = belowTop & {LANE_COUNT{flagsD[1]}};
    assign laneGrab = grabResults & resultsAvailable;  // a grab only counts while results are held

    for (genvar i = 0; i < LANE_COUNT; i++) begin : gLane
        aggregatingLane lane (
            .clk         (clk),
            .rstN        (rstN),
            .top         (top),
            .bot         (i == 0 ? botD : checkedBots[i]),  // identity needs no permuted copy
            .accept      (accept[i]),
            .batchDone   (flagsD[0]),
            .grabResults (laneGrab),
            .resultReady (resultReady[i]),
            .laneSum     (laneSums[i]),
            .laneCount   (laneCounts[i])
        );
    end

    // two-stage adder tree over the lane results
    always_ff @(posedge clk) begin
        sum01       <= {1'b0, laneSums[0]} + {1'b0, laneSums[1]};
        sum23       <= {1'b0, laneSums[2]} + {1'b0, laneSums[3]};
        count01     <= {1'b0, laneCounts[0]} + {1'b0, laneCounts[1]};
        count23     <= {1'b0, laneCounts[2]} + {1'b0, laneCounts[3]};
        pcoeffSum   <= {1'b0, sum01} + {1'b0, sum23};
        pcoeffCount <= {1'b0, count01} + {1'b0, count23};
    end

    // readiness follows the same two stages as the tree
    always_ff @(posedge clk) begin
        if (!rstN) begin
            allReady         <= 1'b0;
            resultsAvailable <= 1'b0;
        end else begin
            allReady         <= &resultReady;
            resultsAvailable <= allReady;
        end
    end

    assign slowDownInput = resultsAvailable;

    // accepting lanes per cycle
    always_ff @(posedge clk) begin
        if (!rstN) begin
            act01           <= '0;
            act23           <= '0;
            activityMeasure <= '0;
        end else begin
            act01           <= {1'b0, accept[0]} + {1'b0, accept[1]};
            act23           <= {1'b0, accept[2]} + {1'b0, accept[3]};
            activityMeasure <= {1'b0, act01} + {1'b0, act23};
        end
    end

endmodule

/* source/aggregatingLane.sv */
`timescale 1ns/1ps

module aggregatingLane import permutePkg::*; (
    input  logic                   clk,
    input  logic                   rstN,
    input  botT                    top,
    input  botT                    bot,
    input  logic                   accept,
    input  logic                   batchDone,
    input  logic                   grabResults,
    output logic                   resultReady,
    output logic [SUM_WIDTH-1:0]   laneSum,
    output logic [COUNT_WIDTH-1:0] laneCount
);

    logic [WEIGHT_WIDTH-1:0] weight;
    logic                    acceptR;
    logic                    doneR;

    logic [SUM_WIDTH-1:0]    accSum;
    logic [COUNT_WIDTH-1:0]  accCount;
    logic [SUM_WIDTH-1:0]    itemSum;
    logic [COUNT_WIDTH-1:0]  itemCount;

    // stage one: weight of this item
    always_ff @(posedge clk) begin
        weight <= WEIGHT_WIDTH'($countones(top & ~bot));  // top bits the bot leaves clear
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            acceptR <= 1'b0;
            doneR   <= 1'b0;
        end else begin
            acceptR <= accept;
            doneR   <= batchDone;
        end
    end

    // contribution of the item in stage two, zero when rejected
    assign itemSum   = acceptR ? SUM_WIDTH'(weight) : '0;
    assign itemCount = COUNT_WIDTH'(acceptR);

    // stage two: accumulate, close the batch on done
    always_ff @(posedge clk) begin
        if (!rstN) begin
            accSum      <= '0;
            accCount    <= '0;
            resultReady <= 1'b0;
        end else if (doneR) begin
            accSum      <= '0;  // next batch starts empty
            accCount    <= '0;
            resultReady <= 1'b1;
        end else begin
            accSum   <= accSum + itemSum;
            accCount <= accCount + itemCount;
            if (grabResults) begin
                resultReady <= 1'b0;
            end
        end
    end

    // result holds until the next done, the last item of the batch included
    always_ff @(posedge clk) begin
        if (doneR) begin
            laneSum   <= accSum + itemSum;
            laneCount <= accCount + itemCount;
        end
    end

endmodule

/* source/permuteCheck.sv */
`timescale 1ns/1ps

module permuteCheck import permutePkg::*; (
    input  logic                  clk,
    input  logic                  rstN,
    input  botT                   top,
    input  botT                   bots [LANE_COUNT],
    input  logic                  botValid,
    output botT                   botsOut [LANE_COUNT],
    output logic [LANE_COUNT-1:0] belowTop
);

    logic [LANE_COUNT-1:0] fits;

    // a bot fits when none of its bits lie outside the top
    always_comb begin
        for (int i = 0; i < LANE_COUNT; i++) begin
            fits[i] = (bots[i] & ~top) == '0;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < LANE_COUNT; i++) begin
            botsOut[i] <= bots[i];
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            belowTop <= '0;
        end else begin
            belowTop <= fits & {LANE_COUNT{botValid}};
        end
    end

endmodule

/* source/varSwap.sv */
`timescale 1ns/1ps

module varSwap import permutePkg::*; #(
    parameter int VAR_A = 0,
    parameter int VAR_B = 1
) (
    input  botT botIn,
    output botT botOut
);

    // output bit k reads the input entry with bits VAR_A and VAR_B of k exchanged,
    // which is the same function with the two variables renamed
    for (genvar k = 0; k < BOT_WIDTH; k++) begin : gBit
        localparam int BIT_A = (k >> VAR_A) & 1;
        localparam int BIT_B = (k >> VAR_B) & 1;
        localparam int KEEP_MASK = ~((1 << VAR_A) | (1 << VAR_B));
        localparam int SRC = (k & KEEP_MASK) | (BIT_A << VAR_B) | (BIT_B << VAR_A);

        assign botOut[k] = botIn[SRC];
    end

endmodule

/* source/topReceiver.sv */
`timescale 1ns/1ps

module topReceiver import permutePkg::*; (
    input  logic       clk,
    input  logic       rstN,
    input  logic [1:0] topChannel,
    input  logic       topShift,
    output botT        top
);

    // most significant pair arrives first, so after eight strobes
    // the first pair sits at the top of the register
    always_ff @(posedge clk) begin
        if (!rstN) begin
            top <= '0;
        end else if (topShift) begin
            top <= {top[BOT_WIDTH-3:0], topChannel};
        end
    end

endmodule

/* source/delayLine.sv */
`timescale 1ns/1ps

module delayLine #(
    parameter int CYCLES = 1,
    parameter type T = logic
) (
    input  logic clk,
    input  T     din,
    output T     dout
);

    T stages [CYCLES];  // stages[0] is the newest sample

    always_ff @(posedge clk) begin
        stages[0] <= din;
        for (int i = 1; i < CYCLES; i++) begin
            stages[i] <= stages[i-1];
        end
    end

    assign dout = stages[CYCLES-1];

endmodule

/* source/permutePkg.sv */
package permutePkg;

    // function size
    localparam int VAR_COUNT = 4;
    localparam int BOT_WIDTH = 2 ** VAR_COUNT;  // truth table bits

    // one lane per permutation: identity plus swaps of var 0 with vars 1, 2, 3
    localparam int LANE_COUNT = 4;

    // a weight counts top bits missing from the bot, so 0 up to BOT_WIDTH
    localparam int WEIGHT_WIDTH = 5;

    // per-lane accumulators
    localparam int COUNT_WIDTH = 16;
    localparam int SUM_WIDTH = COUNT_WIDTH + WEIGHT_WIDTH;

    // combined outputs grow two bits over the four-lane adder tree
    localparam int TOTAL_COUNT_WIDTH = COUNT_WIDTH + 2;
    localparam int TOTAL_SUM_WIDTH = SUM_WIDTH + 2;

    // input bot to registered below-top flags
    localparam int CHECK_LATENCY = 1;

    // bit k holds f(x) where x[j] = k[j]
    typedef logic [BOT_WIDTH-1:0] botT;

endpackage
